// ==== Makefile ====
# Verilator build and run of the exponential unit testbench

VERILATOR ?= verilator
TOP       ?= exponentiator_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o sim
	./$(BUILD_DIR)/sim 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "TB PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== include/exp_model.svh ====
// Testbench helpers for the exponential unit.
// Include inside the testbench module; words up to 32 bits wide.
`ifndef EXP_MODEL_SVH
`define EXP_MODEL_SVH

// 32-bit xorshift step for random stimulus
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] v;
  v = s ^ (s << 13);
  v = v ^ (v >> 17);
  v = v ^ (v << 5);
  return v;
endfunction

// Clamp to the signed range of a data_size word
function automatic longint clamp_word(input longint v, input int data_size);
  longint hi;
  longint lo;
  hi = (longint'(1) << (data_size - 1)) - 1;
  lo = -hi - 1;
  return (v > hi) ? hi : ((v < lo) ? lo : v);
endfunction

// Fixed-point multiply with arithmetic shift and clamp
function automatic longint scaled_mul(input longint a, input longint b,
                                      input int data_size, input int frac_size);
  return clamp_word((a * b) >>> frac_size, data_size);
endfunction

// Round-to-nearest of 2^frac_size / k as (2^(frac_size+1) + k) / 2k
function automatic longint inverse_coef(input int k, input int frac_size);
  longint twice_one;
  twice_one = longint'(1) << (frac_size + 1);
  return (twice_one + longint'(k)) / longint'(2 * k);
endfunction

// Bit-exact truncated Taylor series
function automatic longint exp_model(input longint x, input int data_size,
                                     input int frac_size, input int terms);
  longint term;
  longint sum;
  term = longint'(1) << frac_size;
  sum  = term;
  for (int k = 1; k < terms; k++) begin
    term = scaled_mul(term, x, data_size, frac_size);
    term = scaled_mul(term, inverse_coef(k, frac_size), data_size, frac_size);
    sum  = clamp_word(sum + term, data_size);
  end
  return sum;
endfunction

`endif

// ==== bench/exponentiator_tb.sv ====
// Table-driven testbench for the vector exponential unit.
// Runs fixed vectors and one random vector, checks every result strobe
// against the bit-exact Taylor model, plus READY placement.
`timescale 1ns/1ps

module exponentiator_tb;

  `include "exp_model.svh"

  localparam int DW      = ntm_fixed_pkg::DEFAULT_DATA_SIZE;
  localparam int FW      = ntm_fixed_pkg::DEFAULT_FRAC_SIZE;
  localparam int TERMS   = ntm_fixed_pkg::DEFAULT_TERMS;
  localparam int CW      = ntm_fixed_pkg::DEFAULT_CONTROL_SIZE;
  localparam int LAT     = 2 * (TERMS - 1) + 1;
  localparam int N_ROWS  = 6;
  localparam int N_RAND  = 20;
  localparam int MAX_GAP = 3;

  logic          CLK;
  logic          RST;
  logic          START;
  logic [CW-1:0] SIZE_IN;
  logic          DATA_IN_ENABLE;
  logic [DW-1:0] DATA_IN;
  logic          READY;
  logic          DATA_OUT_ENABLE;
  logic [DW-1:0] DATA_OUT;

  //////////////////////////////
  // Stimulus table
  //////////////////////////////

  string                row_name [N_ROWS];
  int                   row_len  [N_ROWS];
  int                   row_gap  [N_ROWS];
  logic signed [DW-1:0] row_data [N_ROWS][8];
  longint               row_exp  [N_ROWS][8];

  // Vector being applied
  logic signed [DW-1:0] cur_data [$];
  longint               cur_exp  [$];
  int                   cur_gap  [$];

  // Results still owed by the DUT in input order
  longint exp_val  [$];
  string  exp_name [$];
  bit     exp_last [$];
  bit     empty_pending;

  int     value_errors;
  int     protocol_errors;
  int     cycle_count;
  int     cycle_limit;
  longint mon_exp;
  longint mon_act;
  string  mon_name;
  bit     mon_last;

  exponentiator_top dut (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .SIZE_IN        (SIZE_IN),
    .DATA_IN_ENABLE (DATA_IN_ENABLE),
    .DATA_IN        (DATA_IN),
    .READY          (READY),
    .DATA_OUT_ENABLE(DATA_OUT_ENABLE),
    .DATA_OUT       (DATA_OUT)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // One clock plus the 1 ns drive offset
  task automatic step();
    @(posedge CLK);
    #1;
  endtask

  task automatic load_table();
    row_name[0] = "zero";
    row_name[1] = "positive";
    row_name[2] = "negative";
    row_name[3] = "saturate";
    row_name[4] = "gapped";
    row_name[5] = "empty";
    row_len = '{1, 4, 4, 2, 8, 0};
    // Idle cycles before each DATA_IN_ENABLE beat
    row_gap = '{0, 0, 2, 0, 3, 0};
    // Q16.16 raw words
    row_data[0] = '{0, 0, 0, 0, 0, 0, 0, 0};
    row_data[1] = '{65536, 32768, 131072, 212992, 0, 0, 0, 0};
    row_data[2] = '{-65536, -32768, -131072, -262144, 0, 0, 0, 0};
    // 30.0 clamps terms, 100.0 also clamps the sum
    row_data[3] = '{1966080, 6553600, 0, 0, 0, 0, 0, 0};
    row_data[4] = '{16384, -49152, 98304, -196608, 8192, 327680, -524288, 4096};
    row_data[5] = '{0, 0, 0, 0, 0, 0, 0, 0};
    for (int r = 0; r < N_ROWS; r++) begin
      for (int i = 0; i < 8; i++) begin
        row_exp[r][i] = exp_model(longint'(row_data[r][i]), DW, FW, TERMS);
      end
    end
  endtask

  // Applies cur_data; each element waits for the previous result
  task automatic run_vector(input string name);
    int size;
    size = cur_data.size();
    START   = 1'b1;
    SIZE_IN = CW'(size);
    if (size == 0) begin
      empty_pending = 1'b1;
      step();
      START = 1'b0;
      while (!READY) step();
    end else begin
      step();
      START = 1'b0;
      for (int i = 0; i < size; i++) begin
        repeat (cur_gap[i]) step();
        exp_val.push_back(cur_exp[i]);
        exp_name.push_back(name);
        exp_last.push_back(i == size - 1);
        DATA_IN        = cur_data[i];
        DATA_IN_ENABLE = 1'b1;
        step();
        DATA_IN_ENABLE = 1'b0;
        // START while busy with another length
        if (i == 0) begin
          START   = 1'b1;
          SIZE_IN = CW'(3);
          step();
          START   = 1'b0;
          SIZE_IN = '0;
        end
        do step(); while (!DATA_OUT_ENABLE);
      end
    end
    repeat (3) step();
  endtask

  //////////////////////////////
  // Monitor
  //////////////////////////////

  always @(negedge CLK) begin
    if (!RST && DATA_OUT_ENABLE) begin
      assert (exp_val.size() != 0) else begin
        $display("Result strobe arrived with no element outstanding");
        protocol_errors++;
      end
      if (exp_val.size() != 0) begin
        mon_exp  = exp_val.pop_front();
        mon_name = exp_name.pop_front();
        mon_last = exp_last.pop_front();
        mon_act  = longint'($signed(DATA_OUT));
        assert (mon_act == mon_exp) else begin
          $display("[ERROR] %s expected %0d actual %0d", mon_name, mon_exp, mon_act);
          value_errors++;
        end
        assert (READY == mon_last) else begin
          $display("[ERROR] %s READY expected %0d actual %0d", mon_name, mon_last, READY);
          value_errors++;
        end
      end
    end else if (!RST && READY) begin
      assert (empty_pending) else begin
        $display("READY pulsed while no vector was finishing");
        protocol_errors++;
      end
      empty_pending = 1'b0;
    end
  end

  // Watchdog
  initial begin
    cycle_count = 0;
    #1;
    while (cycle_count < cycle_limit) begin
      @(posedge CLK);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the DUT stopped answering", cycle_limit);
    $display("TB FAILED");
    $finish;
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    logic [31:0] rng;
    int          total;
    RST = 1'b1;
    START = 1'b0;
    SIZE_IN = '0;
    DATA_IN_ENABLE = 1'b0;
    DATA_IN = '0;
    empty_pending = 1'b0;
    value_errors = 0;
    protocol_errors = 0;
    load_table();
    total = N_RAND;
    for (int r = 0; r < N_ROWS; r++) total += row_len[r];
    cycle_limit = 40 + total * (LAT + 2 + MAX_GAP + 3) + (N_ROWS + 1) * 10 + 200;
    repeat (8) @(posedge CLK);
    #1 RST = 1'b0;
    assert (!READY && !DATA_OUT_ENABLE && DATA_OUT == '0) else begin
      $display("Outputs not cleared by reset");
      protocol_errors++;
    end
    repeat (4) step();
    for (int r = 0; r < N_ROWS; r++) begin
      cur_data.delete();
      cur_exp.delete();
      cur_gap.delete();
      for (int i = 0; i < row_len[r]; i++) begin
        cur_data.push_back(row_data[r][i]);
        cur_exp.push_back(row_exp[r][i]);
        cur_gap.push_back(row_gap[r]);
      end
      run_vector(row_name[r]);
    end
    // Random elements in [-2.0, +2.0]
    rng = 32'd96;
    cur_data.delete();
    cur_exp.delete();
    cur_gap.delete();
    for (int i = 0; i < N_RAND; i++) begin
      rng = xorshift32(rng);
      cur_data.push_back(DW'(int'(rng % 32'd262145) - 131072));
      cur_exp.push_back(exp_model(longint'(cur_data[i]), DW, FW, TERMS));
      rng = xorshift32(rng);
      cur_gap.push_back(int'(rng % 32'd4));
    end
    run_vector("random");
    assert (exp_val.size() == 0 && !empty_pending) else begin
      $display("Missing result strobes or READY at end of run");
      protocol_errors++;
    end
    $display("Checks done: %0d value errors, %0d protocol errors",
             value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== logic/exponentiator_top.sv ====
// Top level of the vector exponential unit.
// Parameters default to the number-format package and pass straight down.
`timescale 1ns/1ps

module exponentiator_top #(
  parameter int DATA_SIZE    = ntm_fixed_pkg::DEFAULT_DATA_SIZE,
  parameter int FRAC_SIZE    = ntm_fixed_pkg::DEFAULT_FRAC_SIZE,
  parameter int TERMS        = ntm_fixed_pkg::DEFAULT_TERMS,
  parameter int CONTROL_SIZE = ntm_fixed_pkg::DEFAULT_CONTROL_SIZE
) (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    START,
  input  logic [CONTROL_SIZE-1:0] SIZE_IN,
  input  logic                    DATA_IN_ENABLE,
  input  logic [DATA_SIZE-1:0]    DATA_IN,
  output logic                    READY,
  output logic                    DATA_OUT_ENABLE,
  output logic [DATA_SIZE-1:0]    DATA_OUT
);

  // Vector sequencer with its scalar unit
  vector_exponentiator #(
    .DATA_SIZE   (DATA_SIZE),
    .FRAC_SIZE   (FRAC_SIZE),
    .TERMS       (TERMS),
    .CONTROL_SIZE(CONTROL_SIZE)
  ) u_vector (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .SIZE_IN        (SIZE_IN),
    .DATA_IN_ENABLE (DATA_IN_ENABLE),
    .DATA_IN        (DATA_IN),
    .READY          (READY),
    .DATA_OUT_ENABLE(DATA_OUT_ENABLE),
    .DATA_OUT       (DATA_OUT)
  );

endmodule

// ==== logic/fixed_multiplier.sv ====
// Combinational signed fixed-point multiplier.
// Full product, arithmetic shift by the fraction width, then clamp
// to the signed word range.
`timescale 1ns/1ps

module fixed_multiplier #(
  parameter int DATA_SIZE = 32,
  parameter int FRAC_SIZE = 16
) (
  input  logic signed [DATA_SIZE-1:0] a,
  input  logic signed [DATA_SIZE-1:0] b,
  output logic signed [DATA_SIZE-1:0] product
);

  // Clamp limits
  localparam logic signed [DATA_SIZE-1:0] MAX_WORD = {1'b0, {(DATA_SIZE-1){1'b1}}};
  localparam logic signed [DATA_SIZE-1:0] MIN_WORD = {1'b1, {(DATA_SIZE-1){1'b0}}};

  // Double width product and its rescaled form
  logic signed [2*DATA_SIZE-1:0] full;
  logic signed [2*DATA_SIZE-1:0] shifted;

  // Bits above the kept word, including its sign bit
  logic [DATA_SIZE:0] upper;
  logic               overflow;

  assign full    = a * b;
  assign shifted = full >>> FRAC_SIZE;
  assign upper   = shifted[2*DATA_SIZE-1:DATA_SIZE-1];

  // Fits only when all upper bits copy the sign
  assign overflow = !((&upper) || !(|upper));

  always_comb begin
    if (overflow) begin
      // Direction from the true sign of the product
      product = shifted[2*DATA_SIZE-1] ? MIN_WORD : MAX_WORD;
    end else begin
      product = shifted[DATA_SIZE-1:0];
    end
  end

endmodule

// ==== logic/ntm_ctrl_pkg.sv ====
// Sequencer encodings for the exponential unit.
// One type per FSM, vector level and scalar level.
package ntm_ctrl_pkg;

  //////////////////////////////
  // Vector sequencer
  //////////////////////////////

  // Idle / wait for element / wait for result
  typedef enum logic [1:0] {
    STARTER = 2'd0,
    INPUT   = 2'd1,
    ENDER   = 2'd2
  } vector_state_t;

  //////////////////////////////
  // Scalar sequencer
  //////////////////////////////

  // MUL_X multiplies term by x, MUL_INV by 1/k and accumulates
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    MUL_X   = 2'd1,
    MUL_INV = 2'd2,
    DONE    = 2'd3
  } scalar_state_t;

endpackage

// ==== logic/ntm_fixed_pkg.sv ====
// Fixed-point number format shared by the exponential datapath.
// Holds the default word geometry and the Taylor coefficient helper.
// Referenced by scoped name from the top level and the scalar unit.
package ntm_fixed_pkg;

  //////////////////////////////
  // Default format
  //////////////////////////////

  // Word width of every element
  localparam int DEFAULT_DATA_SIZE = 32;

  // Q16.16 by default
  localparam int DEFAULT_FRAC_SIZE = 16;

  // Terms of the series, k = 0 .. TERMS-1
  localparam int DEFAULT_TERMS = 8;

  // Element counter width, vectors up to 255 long
  localparam int DEFAULT_CONTROL_SIZE = 8;

  //////////////////////////////
  // Coefficients
  //////////////////////////////

  // Round-to-nearest of 2^frac_size / k
  // Usable as a constant function for ROM contents
  function automatic longint reciprocal(input int k, input int frac_size);
    longint one;
    one = longint'(1) << frac_size;
    return (one + longint'(k / 2)) / longint'(k);
  endfunction

endpackage

// ==== logic/scalar_exponentiator.sv ====
// Iterative exponential of one fixed-point value by truncated Taylor series.
// Pulse start with data_in; ready pulses with data_out after a fixed
// 2*(TERMS-1)+1 cycles counted from the cycle after start.
// One shared multiplier alternates between x and the 1/k coefficient.
`timescale 1ns/1ps

module scalar_exponentiator #(
  parameter int DATA_SIZE = 32,
  parameter int FRAC_SIZE = 16,
  parameter int TERMS     = 8
) (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        start,
  input  logic signed [DATA_SIZE-1:0] data_in,
  output logic                        ready,
  output logic signed [DATA_SIZE-1:0] data_out
);

  //////////////////////////////
  // Constants
  //////////////////////////////

  localparam int K_W = (TERMS > 2) ? $clog2(TERMS) : 1;

  // Fixed-point one, first term and initial sum
  localparam logic signed [DATA_SIZE-1:0] ONE = DATA_SIZE'(1) << FRAC_SIZE;

  localparam logic signed [DATA_SIZE-1:0] MAX_WORD = {1'b0, {(DATA_SIZE-1){1'b1}}};
  localparam logic signed [DATA_SIZE-1:0] MIN_WORD = {1'b1, {(DATA_SIZE-1){1'b0}}};

  localparam logic [K_W-1:0] LAST_K = K_W'(TERMS - 1);

  //////////////////////////////
  // Signals
  //////////////////////////////

  ntm_ctrl_pkg::scalar_state_t state;

  // Term index, 1 .. TERMS-1
  logic [K_W-1:0] k;

  // Datapath registers
  logic signed [DATA_SIZE-1:0] x_reg;
  logic signed [DATA_SIZE-1:0] term;
  logic signed [DATA_SIZE-1:0] sum;

  // Multiplier operands and result
  logic signed [DATA_SIZE-1:0] mul_b;
  logic signed [DATA_SIZE-1:0] product;

  // Saturating accumulator
  logic signed [DATA_SIZE:0]   sum_wide;
  logic signed [DATA_SIZE-1:0] sum_next;

  // Coefficient ROM, entry 0 unused
  logic signed [DATA_SIZE-1:0] recip_rom [0:(1<<K_W)-1];

  //////////////////////////////
  // Datapath
  //////////////////////////////

  assign recip_rom[0] = '0;
  for (genvar i = 1; i < (1 << K_W); i++) begin : g_recip
    assign recip_rom[i] = DATA_SIZE'(ntm_fixed_pkg::reciprocal(i, FRAC_SIZE));
  end

  // x on the first half of each step, 1/k on the second
  assign mul_b = (state == ntm_ctrl_pkg::MUL_X) ? x_reg : recip_rom[k];

  fixed_multiplier #(
    .DATA_SIZE(DATA_SIZE),
    .FRAC_SIZE(FRAC_SIZE)
  ) u_mul (
    .a      (term),
    .b      (mul_b),
    .product(product)
  );

  // Add the finished term, clamp on overflow
  assign sum_wide = sum + product;
  assign sum_next = (sum_wide[DATA_SIZE] != sum_wide[DATA_SIZE-1]) ?
                    (sum_wide[DATA_SIZE] ? MIN_WORD : MAX_WORD) :
                    sum_wide[DATA_SIZE-1:0];

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= ntm_ctrl_pkg::IDLE;
      k     <= '0;
      ready <= 1'b0;
    end else begin
      // Single cycle strobe
      ready <= 1'b0;
      case (state)
        ntm_ctrl_pkg::IDLE: begin
          if (start) begin
            k     <= K_W'(1);
            state <= ntm_ctrl_pkg::MUL_X;
          end
        end
        ntm_ctrl_pkg::MUL_X: begin
          state <= ntm_ctrl_pkg::MUL_INV;
        end
        ntm_ctrl_pkg::MUL_INV: begin
          if (k == LAST_K) begin
            state <= ntm_ctrl_pkg::DONE;
          end else begin
            k     <= k + 1'b1;
            state <= ntm_ctrl_pkg::MUL_X;
          end
        end
        ntm_ctrl_pkg::DONE: begin
          ready <= 1'b1;
          state <= ntm_ctrl_pkg::IDLE;
        end
      endcase
    end
  end

  // Term, sum and result follow the sequencer state
  always_ff @(posedge CLK) begin
    case (state)
      ntm_ctrl_pkg::IDLE: begin
        if (start) begin
          x_reg <= data_in;
          term  <= ONE;
          sum   <= ONE;
        end
      end
      ntm_ctrl_pkg::MUL_X: begin
        // term * x
        term <= product;
      end
      ntm_ctrl_pkg::MUL_INV: begin
        // (term * x) / k, new term joins the sum
        term <= product;
        sum  <= sum_next;
      end
      ntm_ctrl_pkg::DONE: begin
        data_out <= sum;
      end
    endcase
  end

endmodule

// ==== logic/vector_exponentiator.sv ====
// Vector exponential sequencer around one scalar exponentiator.
// START samples SIZE_IN, then each DATA_IN_ENABLE beat feeds one element.
// Each result leaves on a DATA_OUT_ENABLE strobe; READY marks the last.
`timescale 1ns/1ps

module vector_exponentiator #(
  parameter int DATA_SIZE    = 32,
  parameter int FRAC_SIZE    = 16,
  parameter int TERMS        = 8,
  parameter int CONTROL_SIZE = 8
) (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    START,
  input  logic [CONTROL_SIZE-1:0] SIZE_IN,
  input  logic                    DATA_IN_ENABLE,
  input  logic [DATA_SIZE-1:0]    DATA_IN,
  output logic                    READY,
  output logic                    DATA_OUT_ENABLE,
  output logic [DATA_SIZE-1:0]    DATA_OUT
);

  //////////////////////////////
  // Signals
  //////////////////////////////

  ntm_ctrl_pkg::vector_state_t state;

  // Vector length and current element
  logic [CONTROL_SIZE-1:0] size_int;
  logic [CONTROL_SIZE-1:0] index_loop;

  // Scalar unit handshake
  logic                 scalar_start;
  logic                 scalar_ready;
  logic [DATA_SIZE-1:0] scalar_data_in;
  logic [DATA_SIZE-1:0] scalar_data_out;

  // Element taken this cycle
  logic accept;

  assign accept = (state == ntm_ctrl_pkg::INPUT) && DATA_IN_ENABLE;

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= ntm_ctrl_pkg::STARTER;
      size_int        <= '0;
      index_loop      <= '0;
      scalar_start    <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      DATA_OUT        <= '0;
    end else begin
      // Strobes default low
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      scalar_start    <= 1'b0;
      case (state)
        ntm_ctrl_pkg::STARTER: begin
          if (START) begin
            size_int   <= SIZE_IN;
            index_loop <= '0;
            if (SIZE_IN == '0) begin
              // Empty vector, finish at once
              READY <= 1'b1;
            end else begin
              state <= ntm_ctrl_pkg::INPUT;
            end
          end
        end
        ntm_ctrl_pkg::INPUT: begin
          // Every element restarts the scalar unit
          if (accept) begin
            scalar_start <= 1'b1;
            state        <= ntm_ctrl_pkg::ENDER;
          end
        end
        ntm_ctrl_pkg::ENDER: begin
          if (scalar_ready) begin
            DATA_OUT        <= scalar_data_out;
            DATA_OUT_ENABLE <= 1'b1;
            if (index_loop == size_int - 1'b1) begin
              READY <= 1'b1;
              state <= ntm_ctrl_pkg::STARTER;
            end else begin
              index_loop <= index_loop + 1'b1;
              state      <= ntm_ctrl_pkg::INPUT;
            end
          end
        end
        default: begin
          state <= ntm_ctrl_pkg::STARTER;
        end
      endcase
    end
  end

  // Element register, loaded with the accepting beat
  always_ff @(posedge CLK) begin
    if (accept) begin
      scalar_data_in <= DATA_IN;
    end
  end

  //////////////////////////////
  // Scalar unit
  //////////////////////////////

  scalar_exponentiator #(
    .DATA_SIZE(DATA_SIZE),
    .FRAC_SIZE(FRAC_SIZE),
    .TERMS    (TERMS)
  ) u_scalar (
    .CLK     (CLK),
    .RST     (RST),
    .start   (scalar_start),
    .data_in (scalar_data_in),
    .ready   (scalar_ready),
    .data_out(scalar_data_out)
  );

endmodule

// ==== verilog.f ====
+incdir+include
logic/ntm_fixed_pkg.sv
logic/ntm_ctrl_pkg.sv
logic/fixed_multiplier.sv
logic/scalar_exponentiator.sv
logic/vector_exponentiator.sv
logic/exponentiator_top.sv
bench/exponentiator_tb.sv
